// ==== include/decode_consts.svh ====
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// cycles the divider keeps execute busy.
`define DIV_CYCLES 4

`define CAUSE_ILLEGAL 4'd2
`define CAUSE_BREAK   4'd3
`define CAUSE_ECALL   4'd11 // machine mode ecall.

`define OPC_LOAD     7'b0000011
`define OPC_STORE    7'b0100011
`define OPC_OP       7'b0110011
`define OPC_OP_IMM   7'b0010011
`define OPC_LUI      7'b0110111
`define OPC_AUIPC    7'b0010111
`define OPC_JAL      7'b1101111
`define OPC_JALR     7'b1100111
`define OPC_BRANCH   7'b1100011
`define OPC_SYSTEM   7'b1110011
`define OPC_MISC_MEM 7'b0001111

`endif

// ==== logic/decode_pkg.sv ====
package decode_pkg;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc0;
    logic [31:0] instr0;
    logic [31:0] pc1;
    logic [31:0] instr1;
  } fetch_bundle_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS, // forwards the immediate (lui).
    ALU_NOP
  } alu_op_t;

  typedef enum logic [2:0] {
    CLS_ALU,
    CLS_LOAD,
    CLS_STORE,
    CLS_BRANCH,
    CLS_JUMP,
    CLS_MULDIV,
    CLS_SYSTEM,
    CLS_NONE
  } op_class_t;

  typedef struct packed {
    logic        valid;
    op_class_t   op_class;
    alu_op_t     alu_op;
    logic        rden1;
    logic        rden2;
    logic        wren;
    logic        ecall;
    logic        ebreak;
    logic        is_div;
    logic [31:0] imm;
  } decoder_out_t;

  typedef struct packed {
    logic         valid;
    logic [31:0]  pc;
    logic [31:0]  npc;
    logic [31:0]  instr;
    logic [4:0]   waddr;
    logic [4:0]   raddr1;
    logic [4:0]   raddr2;
    decoder_out_t dec;
    logic         exception;
    logic [3:0]   ecause;
    logic [31:0]  etval;
  } decoded_instr_t;

  typedef struct packed {
    decoded_instr_t lane0;
    decoded_instr_t lane1;
  } decoded_pair_t;

  typedef struct packed {
    logic       rden1;
    logic       rden2;
    logic [4:0] raddr1;
    logic [4:0] raddr2;
  } reg_read_t;

  typedef enum logic [1:0] {
    ST_RUN,
    ST_DIV_WAIT,
    ST_FLUSH_RECOVER
  } issue_state_t;

endpackage

// ==== logic/rv_decoder.sv ====
`timescale 1ns/1ps
`include "decode_consts.svh"

module rv_decoder (
  input  logic [31:0]              instr,
  output decode_pkg::decoder_out_t dec
);
  import decode_pkg::*;

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;

  function automatic alu_op_t alu_from_funct3(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0: return alt ? ALU_SUB : ALU_ADD;
      3'd1: return ALU_SLL;
      3'd2: return ALU_SLT;
      3'd3: return ALU_SLTU;
      3'd4: return ALU_XOR;
      3'd5: return alt ? ALU_SRA : ALU_SRL;
      3'd6: return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'd0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    dec = '0;
    dec.op_class = CLS_NONE;
    dec.alu_op = ALU_NOP;
    case (opcode)
      `OPC_LUI: begin
        dec.valid = 1'b1;
        dec.op_class = CLS_ALU;
        dec.alu_op = ALU_PASS;
        dec.wren = 1'b1;
        dec.imm = imm_u;
      end
      `OPC_AUIPC: begin
        dec.valid = 1'b1;
        dec.op_class = CLS_JUMP; // pc relative, handled next to the jumps.
        dec.alu_op = ALU_ADD;
        dec.wren = 1'b1;
        dec.imm = imm_u;
      end
      `OPC_JAL: begin
        dec.valid = 1'b1;
        dec.op_class = CLS_JUMP;
        dec.alu_op = ALU_ADD;
        dec.wren = 1'b1;
        dec.imm = imm_j;
      end
      `OPC_JALR: begin
        dec.valid = (funct3 == 3'd0);
        dec.op_class = CLS_JUMP;
        dec.alu_op = ALU_ADD;
        dec.rden1 = 1'b1;
        dec.wren = 1'b1;
        dec.imm = imm_i;
      end
      `OPC_BRANCH: begin
        dec.valid = (funct3 != 3'd2) && (funct3 != 3'd3);
        dec.op_class = CLS_BRANCH;
        dec.rden1 = 1'b1;
        dec.rden2 = 1'b1;
        dec.imm = imm_b;
      end
      `OPC_LOAD: begin
        dec.valid = (funct3 != 3'd3) && (funct3 != 3'd6) && (funct3 != 3'd7);
        dec.op_class = CLS_LOAD;
        dec.alu_op = ALU_ADD;
        dec.rden1 = 1'b1;
        dec.wren = 1'b1;
        dec.imm = imm_i;
      end
      `OPC_STORE: begin
        dec.valid = (funct3 <= 3'd2);
        dec.op_class = CLS_STORE;
        dec.alu_op = ALU_ADD;
        dec.rden1 = 1'b1;
        dec.rden2 = 1'b1;
        dec.imm = imm_s;
      end
      `OPC_OP_IMM: begin
        dec.op_class = CLS_ALU;
        dec.alu_op = alu_from_funct3(funct3, (funct3 == 3'd5) && instr[30]);
        dec.rden1 = 1'b1;
        dec.wren = 1'b1;
        dec.imm = imm_i;
        if (funct3 == 3'd1) begin
          dec.valid = (funct7 == 7'b0000000);
        end else if (funct3 == 3'd5) begin
          dec.valid = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
        end else begin
          dec.valid = 1'b1;
        end
      end
      `OPC_OP: begin
        dec.rden1 = 1'b1;
        dec.rden2 = 1'b1;
        dec.wren = 1'b1;
        if (funct7 == 7'b0000001) begin
          dec.valid = 1'b1;
          dec.op_class = CLS_MULDIV;
          dec.is_div = funct3[2]; // div, divu, rem, remu.
        end else begin
          dec.valid = (funct7 == 7'b0000000) ||
                      ((funct7 == 7'b0100000) && ((funct3 == 3'd0) || (funct3 == 3'd5)));
          dec.op_class = CLS_ALU;
          dec.alu_op = alu_from_funct3(funct3, instr[30]);
        end
      end
      `OPC_MISC_MEM: begin
        dec.valid = (funct3 == 3'd0); // fence only, behaves as a nop here.
      end
      `OPC_SYSTEM: begin
        dec.op_class = CLS_SYSTEM;
        dec.ecall = (instr == 32'h0000_0073);
        dec.ebreak = (instr == 32'h0010_0073);
        dec.valid = dec.ecall || dec.ebreak; // no csr support.
      end
      default: begin
        dec.valid = 1'b0;
      end
    endcase
  end

endmodule

// ==== logic/issue_fsm.sv ====
`timescale 1ns/1ps

module issue_fsm (
  input  logic clock,
  input  logic reset,
  input  logic div_issued,
  input  logic flush,
  input  logic timer_done,
  output logic timer_start,
  output logic timer_clear,
  output logic hold
);
  import decode_pkg::*;

  issue_state_t state;
  issue_state_t state_next;

  always_comb begin
    state_next = state;
    case (state)
      ST_RUN: begin
        if (div_issued) begin
          state_next = ST_DIV_WAIT;
        end
      end
      ST_DIV_WAIT: begin
        if (timer_done) begin
          state_next = ST_RUN;
        end
      end
      default: begin
        state_next = ST_RUN;
      end
    endcase
    if (flush) begin
      state_next = ST_FLUSH_RECOVER; // flush wins over everything.
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= ST_RUN;
    end else begin
      state <= state_next;
    end
  end

  assign timer_start = (state == ST_RUN) && div_issued && !flush;
  assign timer_clear = flush || (state == ST_FLUSH_RECOVER);
  assign hold = (state != ST_RUN);

endmodule

// ==== logic/div_timer.sv ====
`timescale 1ns/1ps
`include "decode_consts.svh"

module div_timer (
  input  logic clock,
  input  logic reset,
  input  logic start,
  input  logic clear,
  output logic done
);
  localparam int CW = $clog2(`DIV_CYCLES + 1);

  logic [CW-1:0] count;

  always_ff @(posedge clock) begin
    if (!reset) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;
    end else if (start) begin
      count <= CW'(`DIV_CYCLES);
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  assign done = (count == CW'(1)); // last cycle of the window.

endmodule

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ps
`include "decode_consts.svh"

module decode_stage (
  input  logic                      clock,
  input  logic                      reset,
  input  decode_pkg::fetch_bundle_t fetch,
  input  logic                      flush,
  input  decode_pkg::decoder_out_t  dec0,
  input  decode_pkg::decoder_out_t  dec1,
  input  logic                      hold,
  output logic [31:0]               instr0,
  output logic [31:0]               instr1,
  output decode_pkg::decoded_pair_t issue,
  output logic                      div_issued,
  output logic                      fetch_stall,
  output decode_pkg::reg_read_t     rd_req0,
  output decode_pkg::reg_read_t     rd_req1
);
  import decode_pkg::*;

  decoded_pair_t next_pair;
  logic          load_use;
  logic          consume;

  function automatic decoded_instr_t build_lane(input logic [31:0] pc,
                                                input logic [31:0] instr,
                                                input decoder_out_t dec);
    decoded_instr_t lane;
    lane = '0;
    lane.pc = pc;
    lane.npc = pc + ((instr[1:0] == 2'b11) ? 32'd4 : 32'd2); // compressed steps by 2.
    lane.instr = instr;
    lane.waddr = instr[11:7];
    lane.raddr1 = instr[19:15];
    lane.raddr2 = instr[24:20];
    lane.dec = dec;
    return lane;
  endfunction

  function automatic logic reads_reg(input reg_read_t req, input logic [4:0] addr);
    return (req.rden1 && (req.raddr1 == addr)) || (req.rden2 && (req.raddr2 == addr));
  endfunction

  assign instr0 = fetch.instr0;
  assign instr1 = fetch.instr1;

  always_comb begin
    next_pair.lane0 = build_lane(fetch.pc0, fetch.instr0, dec0);
    next_pair.lane1 = build_lane(fetch.pc1, fetch.instr1, dec1);
    next_pair.lane0.valid = fetch.valid;
    next_pair.lane1.valid = fetch.valid && dec1.valid && (dec1.op_class == CLS_ALU);
    if (!dec0.valid) begin
      next_pair.lane0.exception = 1'b1;
      next_pair.lane0.ecause = `CAUSE_ILLEGAL;
      next_pair.lane0.etval = fetch.instr0;
    end else if (dec0.ebreak) begin
      next_pair.lane0.exception = 1'b1;
      next_pair.lane0.ecause = `CAUSE_BREAK;
      next_pair.lane0.etval = fetch.instr0;
    end else if (dec0.ecall) begin
      next_pair.lane0.exception = 1'b1;
      next_pair.lane0.ecause = `CAUSE_ECALL;
      next_pair.lane0.etval = fetch.instr0;
    end
  end

  always_comb begin
    rd_req0.rden1 = dec0.rden1;
    rd_req0.rden2 = dec0.rden2;
    rd_req0.raddr1 = fetch.instr0[19:15];
    rd_req0.raddr2 = fetch.instr0[24:20];
    rd_req1.rden1 = dec1.rden1;
    rd_req1.rden2 = dec1.rden2;
    rd_req1.raddr1 = fetch.instr1[19:15];
    rd_req1.raddr2 = fetch.instr1[24:20];
  end

  // issued load against either fetch lane; x0 never hazards.
  assign load_use = fetch.valid && issue.lane0.valid && (issue.lane0.dec.op_class == CLS_LOAD) &&
                    (issue.lane0.waddr != 5'd0) &&
                    (reads_reg(rd_req0, issue.lane0.waddr) ||
                     reads_reg(rd_req1, issue.lane0.waddr));

  assign fetch_stall = hold || load_use;
  assign consume = fetch.valid && !fetch_stall;
  assign div_issued = consume && !flush && dec0.is_div;

  always_ff @(posedge clock) begin
    if (!reset) begin
      issue <= '0;
    end else if (flush || !consume) begin
      issue <= '0; // bubble.
    end else begin
      issue <= next_pair;
    end
  end

endmodule

// ==== logic/decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit (
  input  logic                      clock,
  input  logic                      reset,
  input  decode_pkg::fetch_bundle_t fetch,
  input  logic                      flush,
  output decode_pkg::decoded_pair_t issue,
  output logic                      fetch_stall,
  output decode_pkg::reg_read_t     rd_req0,
  output decode_pkg::reg_read_t     rd_req1
);
  import decode_pkg::*;

  logic [31:0]  instr0;
  logic [31:0]  instr1;
  decoder_out_t dec0;
  decoder_out_t dec1;
  logic         hold;
  logic         div_issued;
  logic         timer_start;
  logic         timer_clear;
  logic         timer_done;

  decode_stage u_stage (
    .clock       (clock),
    .reset       (reset),
    .fetch       (fetch),
    .flush       (flush),
    .dec0        (dec0),
    .dec1        (dec1),
    .hold        (hold),
    .instr0      (instr0),
    .instr1      (instr1),
    .issue       (issue),
    .div_issued  (div_issued),
    .fetch_stall (fetch_stall),
    .rd_req0     (rd_req0),
    .rd_req1     (rd_req1)
  );

  rv_decoder u_dec0 (
    .instr (instr0),
    .dec   (dec0)
  );

  // lane 1 shares the full decoder, the stage keeps only alu ops.
  rv_decoder u_dec1 (
    .instr (instr1),
    .dec   (dec1)
  );

  issue_fsm u_fsm (
    .clock       (clock),
    .reset       (reset),
    .div_issued  (div_issued),
    .flush       (flush),
    .timer_done  (timer_done),
    .timer_start (timer_start),
    .timer_clear (timer_clear),
    .hold        (hold)
  );

  div_timer u_timer (
    .clock (clock),
    .reset (reset),
    .start (timer_start),
    .clear (timer_clear),
    .done  (timer_done)
  );

endmodule

// ==== bench/decode_unit_properties.sv ====
`timescale 1ns/1ps

module decode_unit_properties (
  input logic                      clock,
  input logic                      reset,
  input logic                      flush,
  input decode_pkg::fetch_bundle_t fetch,
  input decode_pkg::decoded_pair_t issue,
  input logic                      fetch_stall,
  input decode_pkg::reg_read_t     rd_req0,
  input decode_pkg::reg_read_t     rd_req1,
  input decode_pkg::issue_state_t  state
);
  import decode_pkg::*;

  int failures = 0; // failed assertions so far.

  logic [4:0] load_dest;
  logic       load_use;

  assign load_dest = issue.lane0.waddr;

  // issued load whose destination a fetch lane reads.
  assign load_use = fetch.valid && issue.lane0.valid &&
                    (issue.lane0.dec.op_class == CLS_LOAD) && (load_dest != 5'd0) &&
                    ((rd_req0.rden1 && (rd_req0.raddr1 == load_dest)) ||
                     (rd_req0.rden2 && (rd_req0.raddr2 == load_dest)) ||
                     (rd_req1.rden1 && (rd_req1.raddr1 == load_dest)) ||
                     (rd_req1.rden2 && (rd_req1.raddr2 == load_dest)));

  a_flush_bubble: assert property (@(posedge clock) disable iff (!reset)
    flush |=> (!issue.lane0.valid && !issue.lane1.valid))
    else begin
      failures++;
      $error("issue still valid one cycle after flush");
    end

  a_reset_stall: assert property (@(posedge clock) !reset |=> !fetch_stall)
    else begin
      failures++;
      $error("fetch_stall high right after reset");
    end

  // in run only a load-use hazard may stall fetch.
  a_run_stall: assert property (@(posedge clock) disable iff (!reset)
    ((state == ST_RUN) && fetch_stall) |-> load_use)
    else begin
      failures++;
      $error("fetch_stall high in run without a load-use hazard");
    end

endmodule

bind decode_unit decode_unit_properties u_props (
  .clock       (clock),
  .reset       (reset),
  .flush       (flush),
  .fetch       (fetch),
  .issue       (issue),
  .fetch_stall (fetch_stall),
  .rd_req0     (rd_req0),
  .rd_req1     (rd_req1),
  .state       (u_fsm.state)
);

// ==== bench/decode_unit_tb.sv ====
`timescale 1ns/1ps
`include "decode_consts.svh"

module decode_unit_tb;
  import decode_pkg::*;

  localparam int WAIT_LIMIT = 50;
  localparam logic [31:0] NOP = 32'h0000_0013;

  logic          clock = 1'b0;
  logic          reset;
  logic          flush;
  fetch_bundle_t fetch;
  decoded_pair_t issue;
  logic          fetch_stall;
  reg_read_t     rd_req0;
  reg_read_t     rd_req1;

  logic [31:0]   lfsr;
  string         test_name;
  logic [31:0]   pc_next;
  int            n;

  decoded_pair_t exp_issue;
  logic          exp_armed = 1'b0;
  logic          exp_stall;
  logic          consume;
  logic          m_recover = 1'b0;
  int            m_div_left = 0;

  decode_unit u_decode_unit (
    .clock       (clock),
    .reset       (reset),
    .fetch       (fetch),
    .flush       (flush),
    .issue       (issue),
    .fetch_stall (fetch_stall),
    .rd_req0     (rd_req0),
    .rd_req1     (rd_req1)
  );

  always #2 clock = ~clock;

  function automatic logic [31:0] take_bits(input int count);
    logic [31:0] v;
    logic        b;
    v = '0;
    for (int i = 0; i < count; i++) begin
      b = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) begin
        lfsr = lfsr ^ 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1.
      end
      v = {v[30:0], b};
    end
    return v;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [6:0] pick_opcode(input logic [3:0] idx);
    case (idx)
      4'd0, 4'd1, 4'd2, 4'd3: return `OPC_OP;
      4'd4, 4'd5, 4'd6, 4'd7: return `OPC_OP_IMM;
      4'd8: return `OPC_LUI;
      4'd9, 4'd10: return `OPC_LOAD;
      4'd11: return `OPC_STORE;
      4'd12: return `OPC_BRANCH;
      4'd13: return `OPC_JAL;
      4'd14: return `OPC_JALR;
      default: return `OPC_AUIPC;
    endcase
  endfunction

  // registers limited to x0..x7 so hazards show up often.
  function automatic logic [31:0] gen_instr();
    logic [6:0]  opc;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    logic [19:0] imm20;
    logic [1:0]  sel;
    opc = pick_opcode(4'(take_bits(4)));
    rd = 5'(take_bits(3));
    rs1 = 5'(take_bits(3));
    rs2 = 5'(take_bits(3));
    f3 = 3'(take_bits(3));
    imm = 12'(take_bits(12));
    case (opc)
      `OPC_OP: begin
        sel = 2'(take_bits(2));
        if (sel == 2'd0) begin
          f7 = 7'h01;
        end else if ((sel == 2'd1) && ((f3 == 3'd0) || (f3 == 3'd5))) begin
          f7 = 7'h20;
        end else begin
          f7 = 7'h00;
        end
        return enc_r(f7, rs2, rs1, f3, rd, opc);
      end
      `OPC_OP_IMM: begin
        if (f3 == 3'd1) begin
          imm[11:5] = 7'h00;
        end else if (f3 == 3'd5) begin
          imm[11:5] = {1'b0, imm[10], 5'd0}; // srli or srai.
        end
        return enc_i(imm, rs1, f3, rd, opc);
      end
      `OPC_LUI, `OPC_AUIPC, `OPC_JAL: begin
        imm20 = 20'(take_bits(20));
        return {imm20, rd, opc};
      end
      `OPC_LOAD: begin
        if ((f3 == 3'd3) || (f3 >= 3'd6)) begin
          f3 = 3'd2;
        end
        return enc_i(imm, rs1, f3, rd, opc);
      end
      `OPC_STORE, `OPC_BRANCH: begin
        if ((opc == `OPC_STORE) && (f3 > 3'd2)) begin
          f3 = 3'd2;
        end
        if ((opc == `OPC_BRANCH) && ((f3 == 3'd2) || (f3 == 3'd3))) begin
          f3 = 3'd0;
        end
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
      end
      default: return enc_i(imm, rs1, 3'd0, rd, opc);
    endcase
  endfunction

  function automatic fetch_bundle_t bundle_of(input logic [31:0] pc, input logic [31:0] i0,
                                              input logic [31:0] i1);
    fetch_bundle_t b;
    b.valid = 1'b1;
    b.pc0 = pc;
    b.instr0 = i0;
    b.pc1 = pc + 32'd4;
    b.instr1 = i1;
    return b;
  endfunction

  function automatic fetch_bundle_t make_bundle(input logic [31:0] pc);
    logic [31:0] i0;
    logic [31:0] i1;
    i0 = gen_instr();
    i1 = gen_instr();
    return bundle_of(pc, i0, i1);
  endfunction

  function automatic alu_op_t alu_of(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0: return alt ? ALU_SUB : ALU_ADD;
      3'd1: return ALU_SLL;
      3'd2: return ALU_SLT;
      3'd3: return ALU_SLTU;
      3'd4: return ALU_XOR;
      3'd5: return alt ? ALU_SRA : ALU_SRL;
      3'd6: return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  function automatic decoder_out_t mk(input logic v, input op_class_t c, input alu_op_t a,
                                      input logic r1, input logic r2, input logic w,
                                      input logic [31:0] imm);
    decoder_out_t d;
    d = '0;
    d.valid = v;
    d.op_class = c;
    d.alu_op = a;
    d.rden1 = r1;
    d.rden2 = r2;
    d.wren = w;
    d.imm = imm;
    return d;
  endfunction

  // expected decoder fields from the rv32im encoding rules.
  function automatic decoder_out_t ref_decode(input logic [31:0] ins);
    decoder_out_t d;
    logic [2:0]   f3;
    logic [6:0]   f7;
    logic [31:0]  ii;
    logic [31:0]  is;
    logic [31:0]  ib;
    logic [31:0]  iu;
    logic [31:0]  ij;
    logic         ok;
    f3 = ins[14:12];
    f7 = ins[31:25];
    ii = {{20{ins[31]}}, ins[31:20]};
    is = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    ib = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    iu = {ins[31:12], 12'd0};
    ij = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    d = mk(1'b0, CLS_NONE, ALU_NOP, 1'b0, 1'b0, 1'b0, 32'd0);
    case (ins[6:0])
      `OPC_LUI: d = mk(1'b1, CLS_ALU, ALU_PASS, 1'b0, 1'b0, 1'b1, iu);
      `OPC_AUIPC: d = mk(1'b1, CLS_JUMP, ALU_ADD, 1'b0, 1'b0, 1'b1, iu);
      `OPC_JAL: d = mk(1'b1, CLS_JUMP, ALU_ADD, 1'b0, 1'b0, 1'b1, ij);
      `OPC_JALR: d = mk(f3 == 3'd0, CLS_JUMP, ALU_ADD, 1'b1, 1'b0, 1'b1, ii);
      `OPC_BRANCH: begin
        ok = (f3 != 3'd2) && (f3 != 3'd3);
        d = mk(ok, CLS_BRANCH, ALU_NOP, 1'b1, 1'b1, 1'b0, ib);
      end
      `OPC_LOAD: begin
        ok = (f3 <= 3'd2) || (f3 == 3'd4) || (f3 == 3'd5);
        d = mk(ok, CLS_LOAD, ALU_ADD, 1'b1, 1'b0, 1'b1, ii);
      end
      `OPC_STORE: d = mk(f3 < 3'd3, CLS_STORE, ALU_ADD, 1'b1, 1'b1, 1'b0, is);
      `OPC_OP_IMM: begin
        ok = (f3 == 3'd1) ? (f7 == 7'h00) :
             (f3 == 3'd5) ? ((f7 == 7'h00) || (f7 == 7'h20)) : 1'b1;
        d = mk(ok, CLS_ALU, alu_of(f3, (f3 == 3'd5) && ins[30]), 1'b1, 1'b0, 1'b1, ii);
      end
      `OPC_OP: begin
        if (f7 == 7'h01) begin
          d = mk(1'b1, CLS_MULDIV, ALU_NOP, 1'b1, 1'b1, 1'b1, 32'd0);
          d.is_div = (f3 >= 3'd4);
        end else begin
          ok = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
          d = mk(ok, CLS_ALU, alu_of(f3, ins[30]), 1'b1, 1'b1, 1'b1, 32'd0);
        end
      end
      `OPC_MISC_MEM: d = mk(f3 == 3'd0, CLS_NONE, ALU_NOP, 1'b0, 1'b0, 1'b0, 32'd0);
      `OPC_SYSTEM: begin
        d = mk(1'b0, CLS_SYSTEM, ALU_NOP, 1'b0, 1'b0, 1'b0, 32'd0);
        d.ecall = (ins == 32'h0000_0073);
        d.ebreak = (ins == 32'h0010_0073);
        d.valid = d.ecall || d.ebreak;
      end
      default: ;
    endcase
    return d;
  endfunction

  function automatic reg_read_t ref_read(input logic [31:0] ins);
    reg_read_t    r;
    decoder_out_t d;
    d = ref_decode(ins);
    r.rden1 = d.rden1;
    r.rden2 = d.rden2;
    r.raddr1 = ins[19:15];
    r.raddr2 = ins[24:20];
    return r;
  endfunction

  function automatic decoded_instr_t ref_lane(input logic [31:0] pc, input logic [31:0] ins,
                                              input logic lane0);
    decoded_instr_t l;
    decoder_out_t   d;
    d = ref_decode(ins);
    l = '0;
    l.pc = pc;
    l.npc = pc + ((ins[1:0] == 2'b11) ? 32'd4 : 32'd2);
    l.instr = ins;
    l.waddr = ins[11:7];
    l.raddr1 = ins[19:15];
    l.raddr2 = ins[24:20];
    l.dec = d;
    if (lane0) begin
      l.valid = 1'b1;
      if (!d.valid || d.ebreak || d.ecall) begin
        l.exception = 1'b1;
        l.etval = ins;
        l.ecause = !d.valid ? `CAUSE_ILLEGAL : (d.ebreak ? `CAUSE_BREAK : `CAUSE_ECALL);
      end
    end else begin
      l.valid = d.valid && (d.op_class == CLS_ALU); // lane 1 keeps alu ops only.
    end
    return l;
  endfunction

  function automatic decoded_pair_t ref_pair(input fetch_bundle_t b);
    decoded_pair_t p;
    p.lane0 = ref_lane(b.pc0, b.instr0, 1'b1);
    p.lane1 = ref_lane(b.pc1, b.instr1, 1'b0);
    return p;
  endfunction

  function automatic logic uses_reg(input reg_read_t r, input logic [4:0] a);
    return (r.rden1 && (r.raddr1 == a)) || (r.rden2 && (r.raddr2 == a));
  endfunction

  function automatic logic load_hazard(input decoded_pair_t iss, input fetch_bundle_t b);
    logic [4:0] w;
    w = iss.lane0.waddr;
    return b.valid && iss.lane0.valid && (iss.lane0.dec.op_class == CLS_LOAD) && (w != 5'd0) &&
           (uses_reg(ref_read(b.instr0), w) || uses_reg(ref_read(b.instr1), w));
  endfunction

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_pair(input string name, input decoded_pair_t exp,
                            input decoded_pair_t act);
    if (act !== exp) begin
      fail_now($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_read(input string name, input reg_read_t exp, input reg_read_t act);
    if (act !== exp) begin
      fail_now($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_stall(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_now($sformatf("FAIL %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  // compare at the falling edge and predict the next rising edge.
  always @(negedge clock) begin
    if (u_decode_unit.u_props.failures != 0) begin
      fail_now("a bound assertion on the decode unit failed");
    end
    if (exp_armed) begin
      check_pair({test_name, " issue"}, exp_issue, issue);
    end
    exp_stall = m_recover || (m_div_left > 0) || load_hazard(exp_issue, fetch);
    if (reset) begin
      check_stall({test_name, " fetch_stall"}, exp_stall, fetch_stall);
      if (fetch.valid) begin
        check_read({test_name, " rd_req0"}, ref_read(fetch.instr0), rd_req0);
        check_read({test_name, " rd_req1"}, ref_read(fetch.instr1), rd_req1);
      end
    end
    consume = reset && fetch.valid && !exp_stall;
    if (!reset) begin
      m_recover = 1'b0;
      m_div_left = 0;
    end else if (flush) begin
      m_recover = 1'b1;
      m_div_left = 0;
    end else if (m_recover) begin
      m_recover = 1'b0;
    end else if (m_div_left > 0) begin
      m_div_left = m_div_left - 1;
    end else if (consume && ref_decode(fetch.instr0).is_div) begin
      m_div_left = `DIV_CYCLES;
    end
    exp_issue = (!reset || flush || !consume) ? '0 : ref_pair(fetch);
    exp_armed = 1'b1;
  end

  task automatic send(input fetch_bundle_t b);
    int waited;
    waited = 0;
    @(posedge clock);
    fetch <= b;
    @(negedge clock);
    while (fetch_stall) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        fail_now("timeout: fetch_stall never dropped for a held bundle");
      end
      @(negedge clock);
    end
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clock);
      fetch <= '0;
    end
  endtask

  task automatic flush_with(input fetch_bundle_t b);
    @(posedge clock);
    fetch <= b;
    flush <= 1'b1;
    @(posedge clock);
    flush <= 1'b0;
    fetch <= '0;
  endtask

  initial begin
    lfsr = 32'hc33f;
    fetch = '0;
    flush = 1'b0;
    reset = 1'b0;
    test_name = "reset";
    pc_next = 32'h0000_1000;
    repeat (10) @(posedge clock);
    reset <= 1'b1;

    test_name = "random";
    for (n = 0; n < 400; n++) begin
      send(make_bundle(pc_next));
      pc_next += 32'd8;
    end

    test_name = "exceptions";
    send(bundle_of(pc_next, 32'hffff_ffff, NOP));
    send(bundle_of(pc_next + 32'd8, 32'h0000_0001, NOP)); // compressed width so npc is pc + 2.
    send(bundle_of(pc_next + 32'd16, 32'h3000_2073, NOP)); // csr access is illegal.
    send(bundle_of(pc_next + 32'd24, 32'h0010_0073, NOP));
    send(bundle_of(pc_next + 32'd32, 32'h0000_0073, gen_instr()));

    test_name = "load_use";
    send(bundle_of(pc_next, enc_i(12'd0, 5'd1, 3'd2, 5'd5, `OPC_LOAD), NOP));
    send(bundle_of(pc_next + 32'd8, enc_r(7'd0, 5'd2, 5'd5, 3'd0, 5'd6, `OPC_OP), NOP));
    send(bundle_of(pc_next + 32'd16, enc_i(12'd4, 5'd1, 3'd2, 5'd5, `OPC_LOAD), NOP));
    send(bundle_of(pc_next + 32'd24, NOP, enc_r(7'd0, 5'd5, 5'd3, 3'd0, 5'd6, `OPC_OP)));
    send(bundle_of(pc_next + 32'd32, enc_i(12'd0, 5'd1, 3'd2, 5'd0, `OPC_LOAD), NOP));
    send(bundle_of(pc_next + 32'd40, enc_r(7'd0, 5'd0, 5'd0, 3'd0, 5'd6, `OPC_OP), NOP));

    test_name = "division";
    send(bundle_of(pc_next, enc_r(7'h01, 5'd2, 5'd1, 3'd4, 5'd7, `OPC_OP), NOP));
    send(make_bundle(pc_next + 32'd8));
    send(bundle_of(pc_next + 32'd16, enc_r(7'h01, 5'd2, 5'd1, 3'd7, 5'd7, `OPC_OP), NOP));
    send(make_bundle(pc_next + 32'd24));

    test_name = "flush";
    flush_with(make_bundle(pc_next));
    send(make_bundle(pc_next + 32'd8));
    send(bundle_of(pc_next + 32'd16, enc_r(7'h01, 5'd2, 5'd1, 3'd5, 5'd7, `OPC_OP), NOP));
    idle(2);
    flush_with(make_bundle(pc_next + 32'd24));
    send(make_bundle(pc_next + 32'd32));
    send(make_bundle(pc_next + 32'd40));
    idle(4);

    if (u_decode_unit.u_props.failures == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      fail_now("a bound assertion on the decode unit failed");
    end
  end

endmodule

// ==== flist.f ====
+incdir+include
logic/decode_pkg.sv
logic/rv_decoder.sv
logic/issue_fsm.sv
logic/div_timer.sv
logic/decode_stage.sv
logic/decode_unit.sv
bench/decode_unit_properties.sv
bench/decode_unit_tb.sv

// ==== Bender.yml ====
package:
  name: decode_unit

sources:
  - include_dirs:
      - include
    files:
      - logic/decode_pkg.sv
      - logic/rv_decoder.sv
      - logic/issue_fsm.sv
      - logic/div_timer.sv
      - logic/decode_stage.sv
      - logic/decode_unit.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/decode_unit_properties.sv
      - bench/decode_unit_tb.sv
